//--- src.f
arcade_pkg.sv
clock_enables.sv
video_timer.sv
rom_download.sv
rom_slot.sv
rom_arbiter.sv
arcade_game.sv
arcade_game_chk.sv
tb_arcade_game.sv

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_arcade_game \
    -f src.f -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Run failed"; exit 1; } || exit 0

//--- tb_arcade_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_game;

    localparam int MAX_CYCLES = 20000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        downloading;
    logic        ioctl_wr;
    logic [21:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic [21:0] prog_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic        prom_we;
    logic [12:0] char_addr;
    logic [14:0] snd_addr;
    logic        snd_cs;
    logic [15:0] char_data;
    logic        char_ok;
    logic [7:0]  snd_data;
    logic        snd_ok;
    logic        sdram_req;
    logic [21:0] sdram_addr;
    logic        refresh_en;
    logic        sdram_ack;
    logic        data_rdy;
    logic [31:0] data_read;
    logic        rom_ready;
    logic        game_rst_n;
    logic        cen12;
    logic        cen6;
    logic        cen3;
    logic        cen1p5;
    logic [8:0]  h;
    logic [8:0]  v;
    logic        lhbl;
    logic        lvbl;
    logic        hs;
    logic        vs;
    logic        hinit;

    int   error_count = 0;
    int   check_count = 0;
    int   cycles = 0;
    logic seen_snd [0:32767];

    arcade_game #(
        .CLK_SPEED (48)
    ) arcade_game_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .char_addr   (char_addr),
        .snd_addr    (snd_addr),
        .snd_cs      (snd_cs),
        .char_data   (char_data),
        .char_ok     (char_ok),
        .snd_data    (snd_data),
        .snd_ok      (snd_ok),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .refresh_en  (refresh_en),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .rom_ready   (rom_ready),
        .game_rst_n  (game_rst_n),
        .cen12       (cen12),
        .cen6        (cen6),
        .cen3        (cen3),
        .cen1p5      (cen1p5),
        .h           (h),
        .v           (v),
        .lhbl        (lhbl),
        .lvbl        (lvbl),
        .hs          (hs),
        .vs          (vs),
        .hinit       (hinit)
    );

    always #20 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, run stopped", cycles);
            $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // SDRAM model: ack after 1 to 3 cycles, data 1 to 4 cycles later
    initial begin
        int          rs;
        int          wait_cnt;
        logic [31:0] r;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        rs        = 0;
        wait_cnt  = 0;
        forever begin
            @(posedge clk);
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (!rst_n) begin
                rs = 0;
            end else if (rs == 0) begin
                if (sdram_req) begin
                    rs = 1;
                    wait_cnt = int'($urandom_range(2, 0));
                end
            end else if (wait_cnt > 0) begin
                wait_cnt = wait_cnt - 1;
            end else if (rs == 1) begin
                sdram_ack <= 1'b1;
                rs = 2;
                wait_cnt = int'($urandom_range(3, 0));
            end else begin
                r = $urandom;
                data_rdy  <= 1'b1;
                data_read <= {r[15:0], sdram_addr[15:0] ^ 16'hA5C3};
                rs = 0;
            end
        end
    end

    function automatic logic [15:0] rom_word(input logic [21:0] waddr);
        return waddr[15:0] ^ 16'hA5C3;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic write_byte(input logic [21:0] a, input logic [7:0] d);
        logic to_prom;
        to_prom = a >= arcade_pkg::prom_base;
        @(posedge clk);
        ioctl_wr   <= 1'b1;
        ioctl_addr <= a;
        ioctl_data <= d;
        @(posedge clk);
        ioctl_wr <= 1'b0;
        @(negedge clk);
        check_value("prog_we", 32'(prog_we), 32'(!to_prom));
        check_value("prom_we", 32'(prom_we), 32'(to_prom));
        check_value("prog_data", 32'(prog_data), 32'(d));
        if (to_prom) begin
            check_value("prog_addr", 32'(prog_addr), 32'(a - arcade_pkg::prom_base));
        end else begin
            check_value("prog_addr", 32'(prog_addr), 32'(a >> 1));
            check_value("prog_mask", 32'(prog_mask), a[0] ? 32'h1 : 32'h2);
        end
        check_value("rom_ready", 32'(rom_ready), 32'h0);
    endtask

    task automatic download_roms();
        logic [31:0] r;
        logic [21:0] a;
        @(posedge clk);
        downloading <= 1'b1;
        for (int i = 0; i < 60; i++) begin
            r = $urandom;
            if (r[31]) begin
                a = arcade_pkg::prom_base + 22'(r[7:0]);
            end else begin
                a = 22'(r[21:0] % 22'h0C_0000);
            end
            write_byte(a, r[29:22]);
        end
    endtask

    task automatic verify_load_reset();
        int n;
        n = 0;
        @(posedge clk);
        downloading <= 1'b0;
        @(negedge clk);
        while (!rom_ready && n < 10) begin
            check_value("game_rst_n", 32'(game_rst_n), 32'h0);
            @(negedge clk);
            n++;
        end
        if (!rom_ready) begin
            report_failure("rom_ready did not rise after the download ended");
        end
        check_value("game_rst_n", 32'(game_rst_n), 32'h0);
        @(negedge clk);
        check_value("game_rst_n", 32'(game_rst_n), 32'h0);
        @(negedge clk);
        check_value("game_rst_n", 32'(game_rst_n), 32'h1);
    endtask

    task automatic fetch_char_words();
        logic [31:0] r;
        int          n;
        for (int i = 0; i < 40; i++) begin
            r = $urandom;
            @(posedge clk);
            char_addr <= r[12:0];
            // ok of the old address clears one clock later
            @(posedge clk);
            n = 0;
            @(negedge clk);
            while (!char_ok && n < 200) begin
                @(negedge clk);
                n++;
            end
            if (!char_ok) begin
                report_failure("char_ok never rose within 200 cycles");
            end else begin
                check_value("char_data", 32'(char_data),
                            32'(rom_word(arcade_pkg::char_offset + 22'(char_addr))));
            end
        end
    endtask

    task automatic contend_fetches();
        logic [31:0] r;
        int          hold;
        for (int i = 0; i < 30; i++) begin
            r = $urandom;
            hold = int'($urandom_range(30, 1));
            @(posedge clk);
            char_addr <= r[12:0];
            snd_addr  <= r[27:13];
            snd_cs    <= r[28] | r[29];
            if (r[28] | r[29]) begin
                seen_snd[r[27:13]] = 1'b1;
            end
            @(posedge clk);
            for (int c = 0; c < hold; c++) begin
                @(negedge clk);
                if (char_ok) begin
                    check_value("char_data", 32'(char_data),
                                32'(rom_word(arcade_pkg::char_offset + 22'(char_addr))));
                end
                if (snd_ok) begin
                    r = 32'(rom_word(arcade_pkg::snd_offset + 22'(snd_addr >> 1)));
                    check_value("snd_data", 32'(snd_data),
                                snd_addr[0] ? 32'(r[15:8]) : 32'(r[7:0]));
                    if (!snd_cs && !seen_snd[snd_addr]) begin
                        report_failure("snd_ok high with snd_cs low for an unfetched address");
                    end
                end
            end
        end
    endtask

    task automatic count_clock_enables();
        int n;
        int k;
        n = 0;
        @(negedge clk);
        while (!cen1p5 && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (!cen1p5) begin
            report_failure("cen1p5 never pulsed");
        end
        for (int i = 1; i <= 256; i++) begin
            @(negedge clk);
            k = i / 4;
            check_value("cen12", 32'(cen12), 32'(i % 4 == 0));
            check_value("cen6", 32'(cen6), 32'(i % 4 == 0 && k % 2 == 0));
            check_value("cen3", 32'(cen3), 32'(i % 4 == 0 && k % 4 == 0));
            check_value("cen1p5", 32'(cen1p5), 32'(i % 4 == 0 && k % 8 == 0));
        end
    endtask

    task automatic follow_raster();
        int   mh;
        int   mv;
        logic prev_cen6;
        @(negedge clk);
        while (h != 9'd383) begin
            @(negedge clk);
        end
        while (h != 9'd0) begin
            @(negedge clk);
        end
        // Start of a fresh line, v taken as the known reference
        mh = 0;
        mv = int'(v);
        prev_cen6 = cen6;
        for (int c = 0; c < 2 * 384 * 8; c++) begin
            @(negedge clk);
            if (prev_cen6) begin
                if (mh == 383) begin
                    mh = 0;
                    mv = (mv == 263) ? 0 : mv + 1;
                end else begin
                    mh = mh + 1;
                end
            end
            prev_cen6 = cen6;
            check_value("h", 32'(h), 32'(mh));
            check_value("v", 32'(v), 32'(mv));
            check_value("lhbl", 32'(lhbl), 32'(mh < 256));
            check_value("hs", 32'(hs), 32'(mh >= 304 && mh < 336));
            check_value("hinit", 32'(hinit), 32'(mh == 0));
            check_value("lvbl", 32'(lvbl), 32'(mv < 224));
            check_value("vs", 32'(vs), 32'(mv >= 240 && mv < 244));
        end
    endtask

    initial begin
        void'($urandom(48));
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        char_addr   = '0;
        snd_addr    = '0;
        snd_cs      = 1'b0;
        for (int i = 0; i < 32768; i++) begin
            seen_snd[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("refresh_en", 32'(refresh_en), 32'h1);
        check_value("game_rst_n", 32'(game_rst_n), 32'h0);

        download_roms();
        verify_load_reset();
        fetch_char_words();
        contend_fetches();
        count_clock_enables();
        follow_raster();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- arcade_game_chk.sv
`timescale 1ns/1ps
`default_nettype none

module arcade_game_chk (
    input wire        clk,
    input wire        rst_n,
    input wire        sdram_req,
    input wire [21:0] sdram_addr,
    input wire        sdram_ack,
    input wire        cen12,
    input wire        cen6,
    input wire        prog_we,
    input wire        prom_we
);

    // Address held while the request waits
    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> $stable(sdram_addr))
        else $error("sdram_addr moved while sdram_req waited for ack");

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_ack |-> sdram_req)
        else $error("sdram_ack without sdram_req");

    cen6_on_cen12: assert property (@(posedge clk) disable iff (!rst_n)
        cen6 |-> cen12)
        else $error("cen6 pulsed without cen12");

    one_write_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(prog_we && prom_we))
        else $error("prog_we and prom_we high together");

endmodule

bind arcade_game arcade_game_chk arcade_game_chk_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .sdram_req  (sdram_req),
    .sdram_addr (sdram_addr),
    .sdram_ack  (sdram_ack),
    .cen12      (cen12),
    .cen6       (cen6),
    .prog_we    (prog_we),
    .prom_we    (prom_we)
);

`default_nettype wire

//--- arcade_game.sv
`timescale 1ns/1ps
`default_nettype none

module arcade_game #(
    parameter int CLK_SPEED = 48
) (
    input  wire         clk,
    input  wire         rst_n,
    // ROM loader
    input  wire         downloading,
    input  wire         ioctl_wr,
    input  wire  [21:0] ioctl_addr,
    input  wire  [7:0]  ioctl_data,
    output logic [21:0] prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    output logic        prom_we,
    // ROM clients
    input  wire  [12:0] char_addr,
    input  wire  [14:0] snd_addr,
    input  wire         snd_cs,
    output logic [15:0] char_data,
    output logic        char_ok,
    output logic [7:0]  snd_data,
    output logic        snd_ok,
    // SDRAM
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    output logic        refresh_en,
    input  wire         sdram_ack,
    input  wire         data_rdy,
    input  wire  [31:0] data_read,
    // Status
    output logic        rom_ready,
    output logic        game_rst_n,
    // Clock enables and raster
    output logic        cen12,
    output logic        cen6,
    output logic        cen3,
    output logic        cen1p5,
    output logic [8:0]  h,
    output logic [8:0]  v,
    output logic        lhbl,
    output logic        lvbl,
    output logic        hs,
    output logic        vs,
    output logic        hinit
);

    logic        dl_q;
    logic [1:0]  rst_pipe;
    logic        char_req;
    logic        snd_req;
    logic [21:0] char_addr_sd;
    logic [21:0] snd_addr_sd;
    logic        char_done;
    logic        snd_done;
    logic [15:0] slot_word;

    // ROMs are ready once the loader drops downloading
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dl_q      <= 1'b0;
            rom_ready <= 1'b0;
        end else begin
            dl_q <= downloading;
            if (dl_q && !downloading) begin
                rom_ready <= 1'b1;
            end
        end
    end

    // Game reset lifts two clocks after rom_ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_pipe <= 2'b00;
        end else if (!rom_ready) begin
            rst_pipe <= 2'b00;
        end else begin
            rst_pipe <= {rst_pipe[0], 1'b1};
        end
    end

    assign game_rst_n = rst_pipe[1];

    clock_enables #(
        .CLK_SPEED (CLK_SPEED)
    ) clock_enables_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen12  (cen12),
        .cen6   (cen6),
        .cen3   (cen3),
        .cen1p5 (cen1p5)
    );

    video_timer video_timer_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cen6  (cen6),
        .h     (h),
        .v     (v),
        .lhbl  (lhbl),
        .lvbl  (lvbl),
        .hs    (hs),
        .vs    (vs),
        .hinit (hinit)
    );

    rom_download rom_download_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    // Character ROM is always selected
    rom_slot #(
        .data_t (arcade_pkg::char_word_t),
        .AW     (13),
        .OFFSET (arcade_pkg::char_offset)
    ) char_slot_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cs        (1'b1),
        .addr      (char_addr),
        .slot_done (char_done),
        .slot_word (slot_word),
        .slot_req  (char_req),
        .slot_addr (char_addr_sd),
        .data      (char_data),
        .ok        (char_ok)
    );

    rom_slot #(
        .data_t (arcade_pkg::snd_byte_t),
        .AW     (15),
        .OFFSET (arcade_pkg::snd_offset)
    ) snd_slot_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cs        (snd_cs),
        .addr      (snd_addr),
        .slot_done (snd_done),
        .slot_word (slot_word),
        .slot_req  (snd_req),
        .slot_addr (snd_addr_sd),
        .data      (snd_data),
        .ok        (snd_ok)
    );

    rom_arbiter rom_arbiter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .char_req     (char_req),
        .char_addr_sd (char_addr_sd),
        .snd_req      (snd_req),
        .snd_addr_sd  (snd_addr_sd),
        .char_done    (char_done),
        .snd_done     (snd_done),
        .slot_word    (slot_word),
        .sdram_req    (sdram_req),
        .sdram_addr   (sdram_addr),
        .refresh_en   (refresh_en),
        .sdram_ack    (sdram_ack),
        .data_rdy     (data_rdy),
        .data_read    (data_read)
    );

endmodule

`default_nettype wire

//--- rom_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter (
    input  wire         clk,
    input  wire         rst_n,
    // Slot side
    input  wire         char_req,
    input  wire  [21:0] char_addr_sd,
    input  wire         snd_req,
    input  wire  [21:0] snd_addr_sd,
    output logic        char_done,
    output logic        snd_done,
    output logic [15:0] slot_word,
    // SDRAM side
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    output logic        refresh_en,
    input  wire         sdram_ack,
    input  wire         data_rdy,
    input  wire  [31:0] data_read
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACK,
        ST_DATA
    } state_t;

    state_t state;
    logic   sel_snd;
    logic   got;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            sel_snd <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Character ROM wins a tie
                    if (char_req) begin
                        sel_snd <= 1'b0;
                        state   <= ST_ACK;
                    end else if (snd_req) begin
                        sel_snd <= 1'b1;
                        state   <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (sdram_ack) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (data_rdy) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Address is captured while idle and frozen for the whole access
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            sdram_addr <= char_req ? char_addr_sd : snd_addr_sd;
        end
    end

    assign sdram_req  = state == ST_ACK;
    assign refresh_en = (state == ST_IDLE) && !char_req && !snd_req;

    // Done goes back to the granted slot only
    assign got       = (state == ST_DATA) && data_rdy;
    assign char_done = got && !sel_snd;
    assign snd_done  = got && sel_snd;
    assign slot_word = data_read[15:0];

endmodule

`default_nettype wire

//--- rom_slot.sv
`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter type data_t = logic [15:0],
    parameter int  AW     = 13,
    parameter logic [arcade_pkg::sdram_aw-1:0] OFFSET = '0
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              cs,
    input  wire  [AW-1:0]                    addr,
    input  wire                              slot_done,
    input  wire  [15:0]                      slot_word,
    output logic                             slot_req,
    output logic [arcade_pkg::sdram_aw-1:0]  slot_addr,
    output data_t                            data,
    output logic                             ok
);

    localparam int SAW       = arcade_pkg::sdram_aw;
    localparam bit BYTE_WIDE = ($bits(data_t) == 8);

    logic          pending;
    logic          valid;
    logic [AW-1:0] req_addr;
    logic [AW-1:0] cached_addr;
    logic          stale;
    logic          fill;
    logic          start;

    assign stale    = !(valid && cached_addr == addr);
    assign fill     = pending && slot_done;
    assign start    = !pending && cs && stale;
    assign slot_req = pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            valid   <= 1'b0;
            ok      <= 1'b0;
        end else begin
            if (fill) begin
                pending <= 1'b0;
                valid   <= 1'b1;
            end else if (start) begin
                pending <= 1'b1;
            end
            // A fill for an address the client has left never raises ok
            ok <= fill ? (req_addr == addr) : !stale;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            req_addr <= addr;
        end
        if (fill) begin
            cached_addr <= req_addr;
        end
    end

    generate
        if (BYTE_WIDE) begin : g_byte
            assign slot_addr = OFFSET + SAW'(req_addr >> 1);
            always_ff @(posedge clk) begin
                if (fill) begin
                    data <= data_t'(req_addr[0] ? slot_word[15:8] : slot_word[7:0]);
                end
            end
        end else begin : g_word
            assign slot_addr = OFFSET + SAW'(req_addr);
            always_ff @(posedge clk) begin
                if (fill) begin
                    data <= data_t'(slot_word);
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- rom_download.sv
`timescale 1ns/1ps
`default_nettype none

module rom_download (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         downloading,
    input  wire         ioctl_wr,
    input  wire  [21:0] ioctl_addr,
    input  wire  [7:0]  ioctl_data,
    output logic [21:0] prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    output logic        prom_we
);

    logic wr_byte;
    logic to_prom;

    assign wr_byte = downloading && ioctl_wr;
    assign to_prom = ioctl_addr >= arcade_pkg::prom_base;

    // Strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prog_we <= wr_byte && !to_prom;
            prom_we <= wr_byte && to_prom;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_byte) begin
            prog_data <= ioctl_data;
            // Low mask bit enables its byte
            // Odd addresses land in the high byte
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            if (to_prom) begin
                prog_addr <= ioctl_addr - arcade_pkg::prom_base;
            end else begin
                prog_addr <= {1'b0, ioctl_addr[21:1]};
            end
        end
    end

endmodule

`default_nettype wire

//--- video_timer.sv
`timescale 1ns/1ps
`default_nettype none

module video_timer (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        cen6,
    output logic [8:0] h,
    output logic [8:0] v,
    output logic       lhbl,
    output logic       lvbl,
    output logic       hs,
    output logic       vs,
    output logic       hinit
);

    logic [8:0] h_nxt;
    logic [8:0] v_nxt;

    // Next raster position
    always_comb begin
        h_nxt = h + 9'd1;
        v_nxt = v;
        if (h == arcade_pkg::h_total - 9'd1) begin
            h_nxt = '0;
            if (v == arcade_pkg::v_total - 9'd1) begin
                v_nxt = '0;
            end else begin
                v_nxt = v + 9'd1;
            end
        end
    end

    // Decode from the next position so flags move with the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h     <= '0;
            v     <= '0;
            lhbl  <= 1'b1;
            lvbl  <= 1'b1;
            hs    <= 1'b0;
            vs    <= 1'b0;
            hinit <= 1'b1;
        end else if (cen6) begin
            h     <= h_nxt;
            v     <= v_nxt;
            lhbl  <= h_nxt < arcade_pkg::h_active;
            lvbl  <= v_nxt < arcade_pkg::v_active;
            hs    <= (h_nxt >= arcade_pkg::hs_start) && (h_nxt < arcade_pkg::hs_end);
            vs    <= (v_nxt >= arcade_pkg::vs_start) && (v_nxt < arcade_pkg::vs_end);
            hinit <= h_nxt == 9'd0;
        end
    end

endmodule

`default_nettype wire

//--- clock_enables.sv
`timescale 1ns/1ps
`default_nettype none

module clock_enables #(
    parameter int CLK_SPEED = 48
) (
    input  wire  clk,
    input  wire  rst_n,
    output logic cen12,
    output logic cen6,
    output logic cen3,
    output logic cen1p5
);

    // Fast clocks per 12 MHz period
    localparam int DIV = CLK_SPEED / 12;
    localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] cnt;
    logic [2:0]    sub;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            sub    <= '0;
            cen12  <= 1'b0;
            cen6   <= 1'b0;
            cen3   <= 1'b0;
            cen1p5 <= 1'b0;
        end else if (cnt == CW'(DIV - 1)) begin
            cnt    <= '0;
            sub    <= sub + 3'd1;
            cen12  <= 1'b1;
            // Slower enables ride on a cen12 pulse
            cen6   <= sub[0];
            cen3   <= &sub[1:0];
            cen1p5 <= &sub;
        end else begin
            cnt    <= cnt + CW'(1);
            cen12  <= 1'b0;
            cen6   <= 1'b0;
            cen3   <= 1'b0;
            cen1p5 <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- arcade_pkg.sv
`default_nettype none

package arcade_pkg;

    // SDRAM address map, in 16-bit words
    localparam int sdram_aw = 22;

    // Loader byte address where the PROM region starts
    localparam logic [sdram_aw-1:0] prom_base = 22'h0C_0000;

    localparam logic [sdram_aw-1:0] char_offset = 22'h02_4000;
    localparam logic [sdram_aw-1:0] snd_offset  = 22'h02_0000;

    // Horizontal raster, in 6 MHz pixels
    localparam logic [8:0] h_total  = 9'd384;
    localparam logic [8:0] h_active = 9'd256;
    localparam logic [8:0] hs_start = 9'd304;
    localparam logic [8:0] hs_end   = 9'd336;

    // Vertical raster, in lines
    localparam logic [8:0] v_total  = 9'd264;
    localparam logic [8:0] v_active = 9'd224;
    localparam logic [8:0] vs_start = 9'd240;
    localparam logic [8:0] vs_end   = 9'd244;

    // ROM payloads
    typedef logic [15:0] char_word_t;
    typedef logic [7:0]  snd_byte_t;

endpackage

`default_nettype wire
